/* filelist.f */
+incdir+tests
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/alu.sv
rtl/gpr_file.sv
rtl/forward_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/cpu_core.sv
tests/tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - rtl/core_pkg.sv
  - rtl/core_ifs.sv
  - rtl/alu.sv
  - rtl/gpr_file.sv
  - rtl/forward_unit.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/cpu_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cpu_core.sv

/* tests/ref_model.svh */
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////////////////////////////////////////////
// Reference execution
////////////////////////////////////////////////////////////

// Runs one instruction on model_regs in issue order
function automatic void apply_instr(input logic [31:0] ins, input int unsigned issue_cyc);
    logic [5:0]  opc;
    logic [5:0]  fn;
    logic [4:0]  rd;
    logic [4:0]  sa;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sx;
    logic [31:0] zx;
    logic [31:0] res;
    logic        wr;
    opc = ins[31:26];
    fn  = ins[5:0];
    sa  = ins[10:6];
    a   = model_regs[ins[25:21]];
    b   = model_regs[ins[20:16]];
    sx  = {{16{ins[15]}}, ins[15:0]};
    zx  = {16'h0000, ins[15:0]};
    res = '0;
    wr  = 1'b1;
    rd  = ins[20:16];
    if (opc == OPC_SPECIAL) begin
        rd = ins[15:11];
        case (fn)
            OPC_FN_ADDU: res = a + b;
            OPC_FN_SUBU: res = a - b;
            OPC_FN_AND:  res = a & b;
            OPC_FN_OR:   res = a | b;
            OPC_FN_XOR:  res = a ^ b;
            OPC_FN_NOR:  res = ~(a | b);
            OPC_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OPC_FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            OPC_FN_SLL:  res = b << sa;
            OPC_FN_SRL:  res = b >> sa;
            OPC_FN_SRA:  res = $signed(b) >>> sa;
            OPC_FN_SLLV: res = b << a[4:0];
            OPC_FN_SRLV: res = b >> a[4:0];
            OPC_FN_SRAV: res = $signed(b) >>> a[4:0];
            OPC_FN_MOVN: begin
                res = a;
                wr  = (b != 32'd0);
            end
            OPC_FN_MOVZ: begin
                res = a;
                wr  = (b == 32'd0);
            end
            default:     wr = 1'b0;
        endcase
    end else begin
        case (opc)
            OPC_ADDIU: res = a + sx;
            OPC_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OPC_SLTIU: res = (a < sx) ? 32'd1 : 32'd0;
            OPC_ANDI:  res = a & zx;
            OPC_ORI:   res = a | zx;
            OPC_XORI:  res = a ^ zx;
            OPC_LUI:   res = {ins[15:0], 16'h0000};
            default:   wr = 1'b0;
        endcase
    end
    // r0 stays zero and never shows a writeback
    if (wr && rd != 5'd0) begin
        model_regs[rd] = res;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_cyc_q.push_back(issue_cyc + 2);
        num_expected++;
    end
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        abort_run("DUT output differs from the model");
    end
endtask

`endif

/* tests/tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import core_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int IDLE_CYCLES = 8;
    localparam int NUM_RAND    = 300;
    localparam int NUM_INSTR   = 2 * (NUM_REGS - 1) + 2 * NUM_RAND;
    // Bubbles, debug reads and idle time on top of the stream
    localparam int RUN_CYCLES  = NUM_INSTR + NUM_RAND + 2 * NUM_REGS + IDLE_CYCLES + 20;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic [REG_ADDR_W-1:0] dbg_reg_addr;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd_addr;
    logic [DATA_W-1:0]     wb_data;
    logic [DATA_W-1:0]     dbg_reg;

    integer                seed;
    int unsigned           cycle = 0;
    int                    num_expected = 0;
    int                    num_checked = 0;
    logic [DATA_W-1:0]     model_regs [0:NUM_REGS-1];
    logic [REG_ADDR_W-1:0] last_rd [0:1];
    logic [REG_ADDR_W-1:0] exp_rd_q [$];
    logic [DATA_W-1:0]     exp_data_q [$];
    int unsigned           exp_cyc_q [$];

    cpu_core cpu_core_inst (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .instr_valid  ( instr_valid  ),
        .instr        ( instr        ),
        .dbg_reg_addr ( dbg_reg_addr ),
        .wb_valid     ( wb_valid     ),
        .wb_rd_addr   ( wb_rd_addr   ),
        .wb_data      ( wb_data      ),
        .dbg_reg      ( dbg_reg      )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    `include "ref_model.svh"

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Random supported instruction, dep pulls sources from the last two destinations
    function automatic logic [31:0] make_instr(input logic dep);
        logic [31:0] r;
        logic [31:0] v;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [5:0]  opc;
        logic [5:0]  fn;
        r   = $random(seed);
        v   = $random(seed);
        rs  = r[4:0];
        rt  = r[9:5];
        opc = OPC_SPECIAL;
        fn  = OPC_FN_ADDU;
        if (dep) begin
            rs = last_rd[r[19]];
            if (r[18]) begin
                rt = last_rd[!r[19]];
            end
        end else begin
            while (rs == last_rd[0] || rs == last_rd[1]) begin
                rs = rs + 5'd1;
            end
            while (rt == last_rd[0] || rt == last_rd[1]) begin
                rt = rt + 5'd1;
            end
        end
        case (r[17:15])
            3'd0, 3'd1: begin
                case (r[22:20])
                    3'd0:    fn = OPC_FN_ADDU;
                    3'd1:    fn = OPC_FN_SUBU;
                    3'd2:    fn = OPC_FN_AND;
                    3'd3:    fn = OPC_FN_OR;
                    3'd4:    fn = OPC_FN_XOR;
                    3'd5:    fn = OPC_FN_NOR;
                    3'd6:    fn = OPC_FN_SLT;
                    default: fn = OPC_FN_SLTU;
                endcase
            end
            3'd2: fn = (r[21:20] == 2'd0) ? OPC_FN_SLL : (r[20] ? OPC_FN_SRA : OPC_FN_SRL);
            3'd3: fn = (r[21:20] == 2'd0) ? OPC_FN_SLLV : (r[20] ? OPC_FN_SRAV : OPC_FN_SRLV);
            3'd4: begin
                fn = r[20] ? OPC_FN_MOVN : OPC_FN_MOVZ;
                // r0 as rt gives a known zero condition
                if (r[21]) begin
                    rt = 5'd0;
                end
            end
            3'd5, 3'd6: begin
                case (r[22:20])
                    3'd0:    opc = OPC_ADDIU;
                    3'd1:    opc = OPC_SLTI;
                    3'd2:    opc = OPC_SLTIU;
                    3'd3:    opc = OPC_ANDI;
                    3'd4:    opc = OPC_ORI;
                    3'd5:    opc = OPC_XORI;
                    default: opc = OPC_ADDIU;
                endcase
            end
            default: opc = OPC_LUI;
        endcase
        if (opc == OPC_SPECIAL) begin
            return {opc, rs, rt, r[14:10], v[10:6], fn};
        end
        return {opc, rs, rt, v[15:0]};
    endfunction

    task automatic issue(input logic [31:0] ins);
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = ins;
        apply_instr(ins, cycle);
        last_rd[1] = last_rd[0];
        last_rd[0] = (ins[31:26] == OPC_SPECIAL) ? ins[15:11] : ins[20:16];
    endtask

    // Idle slot with a junk word that decode must ignore
    task automatic bubble();
        @(negedge clk);
        instr_valid = 1'b0;
        instr       = $random(seed);
    endtask

    task automatic read_back_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge clk);
            dbg_reg_addr = r[REG_ADDR_W-1:0];
            @(posedge clk);
            check_value($sformatf("dbg_reg[%0d]", r), dbg_reg, model_regs[r]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback comparison
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst && $isunknown(wb_valid)) begin
            abort_run("wb_valid is unknown after reset");
        end else if (!rst && wb_valid) begin
            if (exp_rd_q.size() == 0) begin
                abort_run("a writeback appeared when none was expected");
            end else begin
                check_value("writeback cycle", cycle, exp_cyc_q.pop_front());
                check_value("wb_rd_addr", wb_rd_addr, exp_rd_q.pop_front());
                check_value("wb_data", wb_data, exp_data_q.pop_front());
                num_checked++;
            end
        end else if (!rst && exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cycle) begin
            abort_run("an expected writeback did not appear on time");
        end
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        abort_run("watchdog expired before the run finished");
    end

    initial begin
        logic [31:0] v;
        seed         = 32'he316_185f;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        dbg_reg_addr = '0;
        last_rd[0]   = '0;
        last_rd[1]   = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Quiet pipeline and cleared register file
        repeat (IDLE_CYCLES) @(negedge clk);
        read_back_regs();

        // Load every register, ori depends on the lui just before it
        for (int r = 1; r < NUM_REGS; r++) begin
            v = $random(seed);
            issue({OPC_LUI, 5'd0, r[4:0], v[31:16]});
            issue({OPC_ORI, r[4:0], r[4:0], v[15:0]});
        end
        repeat (NUM_RAND) issue(make_instr(1'b0));

        // Distance 1 and 2 dependencies, bubbles move some onto the bypass
        repeat (NUM_RAND) begin
            if (($random(seed) & 7) == 0) begin
                bubble();
            end
            issue(make_instr(1'b1));
        end
        @(negedge clk);
        instr_valid = 1'b0;

        while (exp_rd_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        read_back_regs();

        if (num_checked != num_expected || num_checked == 0) begin
            abort_run($sformatf("checked %0d writebacks, expected %0d", num_checked,
                                num_expected));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    input  logic [REG_ADDR_W-1:0] dbg_reg_addr,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd_addr,
    output logic [DATA_W-1:0]     wb_data,
    output logic [DATA_W-1:0]     dbg_reg
);

    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;
    logic [DATA_W-1:0]     fwd_a;
    logic [DATA_W-1:0]     fwd_b;

    decode_bus dec_if ();
    wb_bus     wb_if ();

    ////////////////////////////////////////////////////////////
    // Decode and register file
    ////////////////////////////////////////////////////////////

    decode_stage decode_stage_inst (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .instr_valid ( instr_valid ),
        .instr       ( instr       ),
        .rs_addr     ( rs_addr     ),
        .rt_addr     ( rt_addr     ),
        .rs_data     ( rs_data     ),
        .rt_data     ( rt_data     ),
        .dec         ( dec_if      )
    );

    gpr_file gpr_file_inst (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .rs_addr      ( rs_addr      ),
        .rt_addr      ( rt_addr      ),
        .rs_data      ( rs_data      ),
        .rt_data      ( rt_data      ),
        .wb           ( wb_if        ),
        .dbg_reg_addr ( dbg_reg_addr ),
        .dbg_reg      ( dbg_reg      )
    );

    ////////////////////////////////////////////////////////////
    // Execute with writeback forwarding
    ////////////////////////////////////////////////////////////

    forward_unit forward_unit_inst (
        .dec  ( dec_if ),
        .wb   ( wb_if  ),
        .op_a ( fwd_a  ),
        .op_b ( fwd_b  )
    );

    execute_stage execute_stage_inst (
        .clk  ( clk    ),
        .rst  ( rst    ),
        .dec  ( dec_if ),
        .op_a ( fwd_a  ),
        .op_b ( fwd_b  ),
        .wb   ( wb_if  )
    );

    assign wb_valid   = wb_if.valid;
    assign wb_rd_addr = wb_if.rd_addr;
    assign wb_data    = wb_if.data;

endmodule

`default_nettype wire

/* rtl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    decode_bus.sink           dec,
    input  logic [DATA_W-1:0] op_a,
    input  logic [DATA_W-1:0] op_b,
    wb_bus.source             wb
);

    logic [DATA_W-1:0]  alu_b;
    logic [SHAMT_W-1:0] shamt;
    logic [DATA_W-1:0]  alu_y;
    logic [DATA_W-1:0]  result;
    logic               is_move;
    logic               cond_ok;
    logic               write_en;

    ////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////

    assign alu_b = dec.payload.b_sel ? dec.payload.imm_ext : op_b;
    assign shamt = dec.payload.shamt_sel ? op_a[SHAMT_W-1:0] : dec.payload.shamt;

    alu alu_inst (
        .a        ( op_a                 ),
        .b        ( alu_b                ),
        .op       ( dec.payload.alu_op   ),
        .shamt    ( shamt                ),
        .shift_op ( dec.payload.shift_op ),
        .sel      ( dec.payload.res_sel  ),
        .y        ( alu_y                )
    );

    // movn and movz copy rs and write only on the rt condition
    assign is_move = dec.payload.movn || dec.payload.movz;

    always_comb begin
        cond_ok = 1'b1;
        if (dec.payload.movn) begin
            cond_ok = (op_b != '0);
        end else if (dec.payload.movz) begin
            cond_ok = (op_b == '0);
        end
    end

    assign result   = is_move ? op_a : alu_y;
    assign write_en = dec.valid && dec.payload.reg_w && cond_ok;

    ////////////////////////////////////////////////////////////
    // Execute to writeback register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= write_en;
        end
    end

    always_ff @(posedge clk) begin
        wb.rd_addr <= dec.payload.rd_addr;
        wb.data    <= result;
    end

    a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb.valid |-> (wb.rd_addr != '0));

endmodule

`default_nettype wire

/* rtl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr,
    input  logic [DATA_W-1:0]     rs_data,
    input  logic [DATA_W-1:0]     rt_data,
    decode_bus.source             dec
);

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [15:0]           imm;
    logic                  known;
    logic                  use_rd;
    logic                  sign_ext;
    decoded_t              d;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign rd_field = instr[15:11];
    assign imm      = instr[15:0];
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];

    always_comb begin
        d.alu_op    = ALU_ADD;
        d.shift_op  = SH_SLL;
        d.res_sel   = RES_ALU;
        d.shamt_sel = 1'b0;
        d.shamt     = instr[10:6];
        d.rs_addr   = rs_addr;
        d.rt_addr   = rt_addr;
        d.op_a      = rs_data;
        d.op_b      = rt_data;
        d.movn      = 1'b0;
        d.movz      = 1'b0;
        known       = 1'b1;
        use_rd      = (opcode == OPC_SPECIAL);
        d.b_sel     = !use_rd;
        // Logic immediates are zero-extended, the rest sign-extended
        sign_ext    = !(opcode inside {OPC_ANDI, OPC_ORI, OPC_XORI});
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    OPC_FN_SLL, OPC_FN_SRL, OPC_FN_SRA,
                    OPC_FN_SLLV, OPC_FN_SRLV, OPC_FN_SRAV: begin
                        // funct[2] marks the variable shifts
                        d.res_sel   = RES_SHIFT;
                        d.shamt_sel = funct[2];
                        d.shift_op  = (funct[1:0] == 2'b00) ? SH_SLL :
                                      (funct[0] ? SH_SRA : SH_SRL);
                    end
                    OPC_FN_MOVZ: d.movz = 1'b1;
                    OPC_FN_MOVN: d.movn = 1'b1;
                    OPC_FN_ADDU: d.alu_op = ALU_ADD;
                    OPC_FN_SUBU: d.alu_op = ALU_SUB;
                    OPC_FN_AND:  d.alu_op = ALU_AND;
                    OPC_FN_OR:   d.alu_op = ALU_OR;
                    OPC_FN_XOR:  d.alu_op = ALU_XOR;
                    OPC_FN_NOR:  d.alu_op = ALU_NOR;
                    OPC_FN_SLT:  d.alu_op = ALU_SLT;
                    OPC_FN_SLTU: d.alu_op = ALU_SLTU;
                    default:     known = 1'b0;
                endcase
            end
            OPC_ADDIU: d.alu_op = ALU_ADD;
            OPC_SLTI:  d.alu_op = ALU_SLT;
            OPC_SLTIU: d.alu_op = ALU_SLTU;
            OPC_ANDI:  d.alu_op = ALU_AND;
            OPC_ORI:   d.alu_op = ALU_OR;
            OPC_XORI:  d.alu_op = ALU_XOR;
            OPC_LUI:   d.alu_op = ALU_LUI;
            default:   known = 1'b0;
        endcase
        d.imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
        d.rd_addr = use_rd ? rd_field : rt_addr;
        d.reg_w   = known && (d.rd_addr != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else begin
            dec.valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec.payload <= d;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(dec.valid));

endmodule

`default_nettype wire

/* rtl/forward_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module forward_unit import core_pkg::*; (
    decode_bus.monitor        dec,
    wb_bus.monitor            wb,
    output logic [DATA_W-1:0] op_a,
    output logic [DATA_W-1:0] op_b
);

    logic hit_a;
    logic hit_b;

    // wb valid is never set for r0, so no zero check needed here
    assign hit_a = wb.valid && (wb.rd_addr == dec.payload.rs_addr);
    assign hit_b = wb.valid && (wb.rd_addr == dec.payload.rt_addr);

    ////////////////////////////////////////////////////////////
    // Operand mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (hit_a) begin
            op_a = wb.data;
        end else begin
            op_a = dec.payload.op_a;
        end
    end

    always_comb begin
        if (hit_b) begin
            op_b = wb.data;
        end else begin
            op_b = dec.payload.op_b;
        end
    end

endmodule

`default_nettype wire

/* rtl/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    wb_bus.sink         wb,
    input  logic [4:0]  dbg_reg_addr,
    output logic [31:0] dbg_reg
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd_addr != 5'd0) begin
            regs[wb.rd_addr] <= wb.data;
        end
    end

    // Bypass so decode sees the value being written this cycle
    assign rs_data = (rs_addr == 5'd0) ? '0 :
                     (wb.valid && wb.rd_addr == rs_addr) ? wb.data : regs[rs_addr];
    assign rt_data = (rt_addr == 5'd0) ? '0 :
                     (wb.valid && wb.rd_addr == rt_addr) ? wb.data : regs[rt_addr];

    // Debug view shows committed state only
    assign dbg_reg = regs[dbg_reg_addr];

    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        !(wb.valid && wb.rd_addr == 5'd0));

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  logic [DATA_W-1:0]  a,
    input  logic [DATA_W-1:0]  b,
    input  alu_op_t            op,
    input  logic [SHAMT_W-1:0] shamt,
    input  shift_op_t          shift_op,
    input  res_sel_t           sel,
    output logic [DATA_W-1:0]  y
);

    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] shift_res;

    ////////////////////////////////////////////////////////////
    // Arithmetic and logic
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            ALU_ADD:  alu_res = a + b;
            ALU_SUB:  alu_res = a - b;
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_NOR:  alu_res = ~(a | b);
            ALU_SLT:  alu_res = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: alu_res = {{(DATA_W-1){1'b0}}, a < b};
            ALU_LUI:  alu_res = {b[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    // Barrel shift of rt
    always_comb begin
        case (shift_op)
            SH_SLL:  shift_res = b << shamt;
            SH_SRL:  shift_res = b >> shamt;
            SH_SRA:  shift_res = $unsigned($signed(b) >>> shamt);
            default: shift_res = b;
        endcase
    end

    assign y = (sel == RES_SHIFT) ? shift_res : alu_res;

endmodule

`default_nettype wire

/* rtl/core_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// Decode to execute
////////////////////////////////////////////////////////////

interface decode_bus import core_pkg::*; ();
    logic     valid;
    decoded_t payload;

    modport source (output valid, output payload);
    modport sink (input valid, input payload);

    // Forwarding only looks at the addresses and operands
    modport monitor (input valid, input payload);
endinterface

////////////////////////////////////////////////////////////
// Writeback
////////////////////////////////////////////////////////////

interface wb_bus import core_pkg::*; ();
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     data;

    modport source (output valid, output rd_addr, output data);

    // Register file write port
    modport sink (input valid, input rd_addr, input data);

    modport monitor (input valid, input rd_addr, input data);
endinterface

`default_nettype wire

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    ////////////////////////////////////////////////////////////
    // Opcode and function codes
    ////////////////////////////////////////////////////////////

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_SLTIU   = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // Function field, only valid under OPC_SPECIAL
    localparam logic [5:0] OPC_FN_SLL  = 6'h00;
    localparam logic [5:0] OPC_FN_SRL  = 6'h02;
    localparam logic [5:0] OPC_FN_SRA  = 6'h03;
    localparam logic [5:0] OPC_FN_SLLV = 6'h04;
    localparam logic [5:0] OPC_FN_SRLV = 6'h06;
    localparam logic [5:0] OPC_FN_SRAV = 6'h07;
    localparam logic [5:0] OPC_FN_MOVZ = 6'h0a;
    localparam logic [5:0] OPC_FN_MOVN = 6'h0b;
    localparam logic [5:0] OPC_FN_ADDU = 6'h21;
    localparam logic [5:0] OPC_FN_SUBU = 6'h23;
    localparam logic [5:0] OPC_FN_AND  = 6'h24;
    localparam logic [5:0] OPC_FN_OR   = 6'h25;
    localparam logic [5:0] OPC_FN_XOR  = 6'h26;
    localparam logic [5:0] OPC_FN_NOR  = 6'h27;
    localparam logic [5:0] OPC_FN_SLT  = 6'h2a;
    localparam logic [5:0] OPC_FN_SLTU = 6'h2b;

    ////////////////////////////////////////////////////////////
    // Execute controls
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {SH_SLL, SH_SRL, SH_SRA} shift_op_t;

    typedef enum logic {RES_ALU, RES_SHIFT} res_sel_t;

    // Everything execute needs for one instruction
    typedef struct packed {
        alu_op_t                alu_op;
        shift_op_t              shift_op;
        res_sel_t               res_sel;
        logic                   b_sel;      // 1 selects imm_ext
        logic                   shamt_sel;  // 1 takes shift amount from rs
        logic [SHAMT_W-1:0]     shamt;
        logic [DATA_W-1:0]      imm_ext;
        logic [REG_ADDR_W-1:0]  rs_addr;
        logic [REG_ADDR_W-1:0]  rt_addr;
        logic [REG_ADDR_W-1:0]  rd_addr;
        logic [DATA_W-1:0]      op_a;
        logic [DATA_W-1:0]      op_b;
        logic                   reg_w;
        logic                   movn;
        logic                   movz;
    } decoded_t;

endpackage

`default_nettype wire
